/* source/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	// host operations, one bus word each
	typedef enum logic [2:0] {
		op_clear      = 3'd0,
		op_home       = 3'd1,
		op_set_pos    = 3'd2,
		op_write_char = 3'd3,
		op_raw_cmd    = 3'd4
	} lcd_op_e;

	typedef logic [7:0]  lcd_byte_t;  // panel data or instruction byte
	typedef logic [6:0]  lcd_addr_t;  // ddram address
	typedef logic        lcd_row_t;
	typedef logic [5:0]  lcd_col_t;   // 0 to 39 on a line
	typedef logic [15:0] us_count_t;  // microsecond-scaled cycle counts

	// one bus transfer, same bit order as {rs, rw, data}
	typedef struct packed {
		logic      rs;    // 1 selects the data register
		logic      rw;
		lcd_byte_t data;
	} lcd_word_t;

	typedef struct packed {
		logic two_lines;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;
		logic shift;
	} lcd_cfg_t;

	typedef struct packed {
		lcd_op_e   op;
		lcd_row_t  row;
		lcd_col_t  col;
		lcd_byte_t arg;   // character or raw instruction
	} host_req_t;

endpackage

`default_nettype wire

/* source/lcd_cmd_decoder.sv */
`default_nettype none

module lcd_cmd_decoder import lcd_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req,
	input  host_req_t req_data,
	input  logic      take,
	output logic      full,
	output logic      word_avail,
	output lcd_word_t word
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	lcd_word_t          queue_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic               push;
	logic               pop;
	lcd_word_t          new_word;

	// one host operation to one bus word
	function automatic lcd_word_t decode_req(input host_req_t r);
		lcd_word_t w;
		w = '{rs: 1'b0, rw: 1'b0, data: 8'h00};
		case (r.op)
			op_clear:   w.data = 8'h01;
			op_home:    w.data = 8'h02;
			op_set_pos: w.data = {1'b1, r.row, r.col}; // 0x80 + row*0x40 + col
			op_write_char: begin
				w.rs   = 1'b1;
				w.data = r.arg;
			end
			op_raw_cmd: w.data = r.arg;
			default:    w.data = 8'h00;
		endcase
		return w;
	endfunction

	assign new_word   = decode_req(req_data);
	assign full       = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign word_avail = (count != '0);
	assign push       = req && !full;  // strobe while full is lost
	assign pop        = take && word_avail;
	assign word       = queue_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			queue_mem[wr_ptr] <= new_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// host has to watch full before strobing
	a_no_req_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		req |-> !full
	);

	// bus timer only accepts a word that is there
	a_no_take_when_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> word_avail
	);

endmodule

`default_nettype wire

/* source/lcd_bus_timer.sv */
`default_nettype none

module lcd_bus_timer import lcd_pkg::*; #(
	parameter int CYCLES_PER_US = 40
) (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_cfg_t  cfg,
	input  logic      word_avail,
	input  lcd_word_t word,
	output logic      take,
	output logic      done,
	output logic      init_done,
	output logic      ready,
	output lcd_word_t done_word,
	output logic      e,
	output logic      rs,
	output logic      rw,
	output lcd_byte_t lcd_data
);

	localparam us_count_t U = us_count_t'(CYCLES_PER_US);

	localparam us_count_t T_POWER    = us_count_t'(500 * CYCLES_PER_US);
	// init steps, e-high windows and the waits after them
	localparam us_count_t T_FSET     = us_count_t'(10 * CYCLES_PER_US);
	localparam us_count_t T_DISP_ON  = us_count_t'(60 * CYCLES_PER_US);
	localparam us_count_t T_DISP_OFF = us_count_t'(70 * CYCLES_PER_US);
	localparam us_count_t T_CLR_ON   = us_count_t'(120 * CYCLES_PER_US);
	localparam us_count_t T_CLR_OFF  = us_count_t'(130 * CYCLES_PER_US);
	localparam us_count_t T_ENTRY_ON = us_count_t'(330 * CYCLES_PER_US);
	localparam us_count_t T_ENTRY_OFF = us_count_t'(340 * CYCLES_PER_US);
	localparam us_count_t T_INIT_END = us_count_t'(440 * CYCLES_PER_US);
	// transfer window
	localparam us_count_t T_E_FALL   = us_count_t'(14 * CYCLES_PER_US);
	localparam us_count_t T_XFER_END = us_count_t'(50 * CYCLES_PER_US);

	typedef enum logic [1:0] {
		power_up,
		init_seq,
		idle,
		transfer
	} timer_state_e;

	timer_state_e state;
	us_count_t    cnt;
	us_count_t    cnt_nxt;
	us_count_t    init_pos;
	us_count_t    xfer_pos;
	logic         init_e;
	lcd_byte_t    init_data;
	lcd_word_t    init_word;
	logic         xfer_e;
	lcd_word_t    bus_word;  // drives the pins, held for the whole window

	assign cnt_nxt  = cnt + 1'b1;
	assign init_pos = (state == init_seq) ? cnt_nxt : '0;  // 0 on entry from power_up
	assign xfer_pos = (state == transfer) ? cnt_nxt : us_count_t'(1);

	// fixed init sequence, e high 10 us per instruction
	always_comb begin
		init_e    = 1'b0;
		init_data = '0;
		if (init_pos < T_FSET) begin
			init_e    = 1'b1;
			init_data = {4'b0011, cfg.two_lines, cfg.font_5x10, 2'b00};
		end else if (init_pos >= T_DISP_ON && init_pos < T_DISP_OFF) begin
			init_e    = 1'b1;
			init_data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on};
		end else if (init_pos >= T_CLR_ON && init_pos < T_CLR_OFF) begin
			init_e    = 1'b1;
			init_data = 8'h01;
		end else if (init_pos >= T_ENTRY_ON && init_pos < T_ENTRY_OFF) begin
			init_e    = 1'b1;
			init_data = {6'b000001, cfg.increment, cfg.shift};
		end
	end

	assign init_word = '{rs: 1'b0, rw: 1'b0, data: init_data};
	assign xfer_e    = (xfer_pos >= U) && (xfer_pos < T_E_FALL);  // 13 us high

	assign take      = (state == idle) && word_avail;
	assign ready     = (state == idle);
	assign done_word = bus_word;
	assign rs        = bus_word.rs;
	assign rw        = bus_word.rw;
	assign lcd_data  = bus_word.data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= power_up;
			cnt       <= '0;
			e         <= 1'b0;
			done      <= 1'b0;
			init_done <= 1'b0;
			bus_word  <= '0;
		end else begin
			done      <= 1'b0;
			init_done <= 1'b0;
			case (state)
				power_up: begin
					if (cnt_nxt == T_POWER) begin
						state    <= init_seq;
						cnt      <= '0;
						e        <= init_e;  // function set starts right away
						bus_word <= init_word;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				init_seq: begin
					if (cnt_nxt == T_INIT_END) begin
						state     <= idle;
						cnt       <= '0;
						e         <= 1'b0;
						bus_word  <= '0;
						init_done <= 1'b1;
					end else begin
						cnt      <= cnt_nxt;
						e        <= init_e;
						bus_word <= init_word;
					end
				end
				idle: begin
					if (take) begin
						state    <= transfer;
						cnt      <= us_count_t'(1);  // counts cycles since take
						e        <= xfer_e;
						bus_word <= word;
					end
				end
				transfer: begin
					if (cnt == T_XFER_END) begin
						state    <= idle;
						cnt      <= '0;
						e        <= 1'b0;
						bus_word <= '0;
					end else begin
						cnt  <= cnt_nxt;
						e    <= xfer_e;
						done <= (cnt_nxt == T_XFER_END);
					end
				end
				default: state <= power_up;
			endcase
		end
	end

	a_e_not_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		e |-> state != idle
	);

endmodule

`default_nettype wire

/* source/lcd_cursor_tracker.sv */
`default_nettype none

module lcd_cursor_tracker import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_cfg_t  cfg,
	input  logic      init_done,
	input  logic      done,
	input  lcd_word_t done_word,
	output lcd_row_t  cursor_row,
	output lcd_col_t  cursor_col
);

	localparam lcd_col_t LAST_COL = 6'd39;

	lcd_addr_t addr;
	lcd_col_t  col_step;
	logic      is_clear_home;

	// clear is 0x01, home is 0x02 or 0x03
	assign is_clear_home = (done_word.data == 8'h01) || (done_word.data[7:1] == 7'b0000001);

	// data writes move the column and stay on the row
	always_comb begin
		if (cfg.increment) begin
			col_step = (addr[5:0] >= LAST_COL) ? '0 : addr[5:0] + 1'b1;
		end else begin
			col_step = (addr[5:0] == '0) ? LAST_COL : addr[5:0] - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			addr <= '0;
		end else if (init_done) begin
			addr <= '0;  // init ends with a clear
		end else if (done) begin
			if (done_word.rs) begin
				addr <= {addr[6], col_step};
			end else if (is_clear_home) begin
				addr <= '0;
			end else if (done_word.data[7]) begin
				addr <= done_word.data[6:0];  // set ddram address
			end
		end
	end

	assign cursor_row = addr[6];
	assign cursor_col = addr[5:0];

	a_col_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		cursor_col <= LAST_COL
	);

endmodule

`default_nettype wire

/* source/lcd_text_display.sv */
`default_nettype none

module lcd_text_display import lcd_pkg::*; #(
	parameter int CYCLES_PER_US = 40,
	parameter int QUEUE_DEPTH   = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_cfg_t  cfg,
	input  logic      req,
	input  host_req_t req_data,
	output logic      full,
	output logic      ready,
	output logic      e,
	output logic      rs,
	output logic      rw,
	output lcd_byte_t lcd_data,
	output lcd_row_t  cursor_row,
	output lcd_col_t  cursor_col
);

	lcd_word_t word;
	logic      word_avail;
	logic      take;
	logic      done;
	logic      init_done;
	lcd_word_t done_word;  // word whose window just closed

	lcd_cmd_decoder #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) decoder_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.req_data  (req_data),
		.take      (take),
		.full      (full),
		.word_avail(word_avail),
		.word      (word)
	);

	lcd_bus_timer #(
		.CYCLES_PER_US(CYCLES_PER_US)
	) timer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.word_avail(word_avail),
		.word      (word),
		.take      (take),
		.done      (done),
		.init_done (init_done),
		.ready     (ready),
		.done_word (done_word),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

	lcd_cursor_tracker tracker_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.init_done (init_done),
		.done      (done),
		.done_word (done_word),
		.cursor_row(cursor_row),
		.cursor_col(cursor_col)
	);

endmodule

`default_nettype wire

/* verification/lcd_text_display_tb.sv */
`default_nettype none

module lcd_text_display_tb import lcd_pkg::*; ();

	typedef struct packed {
		lcd_op_e   op;
		lcd_row_t  row;
		lcd_col_t  col;
		lcd_byte_t arg;
		logic      exp_rs;
		lcd_byte_t exp_data;
		lcd_row_t  exp_row;   // cursor once the word is out
		lcd_col_t  exp_col;
	} step_t;

	localparam int       NUM_STEPS = 12;
	localparam lcd_cfg_t CFG       = 7'b1011110;  // two lines, display, cursor, blink, increment

	logic      clk;
	logic      rst_n;
	logic      req;
	host_req_t req_data;
	lcd_cfg_t  cfg;
	logic      full;
	logic      ready;
	logic      e;
	logic      rs;
	logic      rw;
	lcd_byte_t lcd_data;
	lcd_row_t  cursor_row;
	lcd_col_t  cursor_col;

	step_t      steps [NUM_STEPS];
	lcd_byte_t  init_exp [4] = '{8'h38, 8'h0F, 8'h01, 8'h06};  // fset, display, clear, entry
	logic [9:0] word_log [$];   // {rs, rw, data} at each rising e
	int         width_log [$];  // e high time in cycles
	logic [9:0] held_word;
	int         width;
	logic       e_prev;
	int         errors;

	lcd_text_display #(
		.CYCLES_PER_US(2),
		.QUEUE_DEPTH  (4)
	) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// bus monitor samples mid-cycle where the pins are settled
	always @(negedge clk) begin
		if (e && !e_prev) begin
			held_word = {rs, rw, lcd_data};
			word_log.push_back(held_word);
			width = 1;
		end else if (e) begin
			width = width + 1;
			if ({rs, rw, lcd_data} != held_word) begin
				$display("bus word changed while e was high at time %0t", $time);
				errors = errors + 1;
			end
		end else if (e_prev) begin
			width_log.push_back(width);
		end
		e_prev = e;
	end

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %h got %h", name, exp, act);
			errors = errors + 1;
		end
	endtask

	task automatic end_run();
		$display("run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		errors = errors + 1;
		end_run();
	endtask

	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		while (!ready && n < limit) begin
			@(posedge clk);
			#10;
			n++;
		end
		if (!ready) abort_on_timeout("ready");
	endtask

	task automatic wait_words(input int count, input int limit);
		int n;
		n = 0;
		while (word_log.size() < count && n < limit) begin
			@(posedge clk);
			#10;
			n++;
		end
		if (word_log.size() < count) abort_on_timeout("a bus transfer");
	endtask

	// one strobe held off while the queue is full
	task automatic send_req(input lcd_op_e op, input lcd_row_t row, input lcd_col_t col,
			input lcd_byte_t arg);
		int n;
		n = 0;
		while (full && n < 400) begin
			@(posedge clk);
			#10;
			n++;
		end
		if (full) abort_on_timeout("full to fall");
		req      = 1'b1;
		req_data = {op, row, col, arg};
		@(posedge clk);
		#10;
		req = 1'b0;
	endtask

	initial begin
		int base;
		errors   = 0;
		e_prev   = 1'b0;
		width    = 0;
		rst_n    = 1'b0;
		req      = 1'b0;
		req_data = '0;
		cfg      = CFG;
		// op, row, col, arg, then rs, data, row, col expected
		steps[0]  = {op_set_pos,    1'b1, 6'd5,  8'h00, 1'b0, 8'hC5, 1'b1, 6'd5};
		steps[1]  = {op_write_char, 1'b0, 6'd0,  8'h41, 1'b1, 8'h41, 1'b1, 6'd6};
		steps[2]  = {op_write_char, 1'b0, 6'd0,  8'h42, 1'b1, 8'h42, 1'b1, 6'd7};
		steps[3]  = {op_write_char, 1'b0, 6'd0,  8'h43, 1'b1, 8'h43, 1'b1, 6'd8};
		steps[4]  = {op_set_pos,    1'b0, 6'd39, 8'h00, 1'b0, 8'hA7, 1'b0, 6'd39};
		steps[5]  = {op_write_char, 1'b0, 6'd0,  8'h5A, 1'b1, 8'h5A, 1'b0, 6'd0};  // wraps
		steps[6]  = {op_set_pos,    1'b1, 6'd20, 8'h00, 1'b0, 8'hD4, 1'b1, 6'd20};
		steps[7]  = {op_home,       1'b0, 6'd0,  8'h00, 1'b0, 8'h02, 1'b0, 6'd0};
		steps[8]  = {op_raw_cmd,    1'b0, 6'd0,  8'h8A, 1'b0, 8'h8A, 1'b0, 6'd10};
		steps[9]  = {op_write_char, 1'b0, 6'd0,  8'h21, 1'b1, 8'h21, 1'b0, 6'd11};
		steps[10] = {op_raw_cmd,    1'b0, 6'd0,  8'h0C, 1'b0, 8'h0C, 1'b0, 6'd11};  // no move
		steps[11] = {op_clear,      1'b0, 6'd0,  8'h00, 1'b0, 8'h01, 1'b0, 6'd0};
		repeat (10) @(posedge clk);
		#10;
		rst_n = 1'b1;
		check_val("e", 16'h0, e);
		check_val("ready", 16'h0, ready);
		check_val("full", 16'h0, full);

		wait_ready(3000);  // power-up plus init is 1880 cycles
		if (word_log.size() != 4) begin
			$display("init sent %0d words instead of four", word_log.size());
			errors = errors + 1;
		end
		for (int i = 0; i < 4 && i < word_log.size(); i++) begin
			check_val("init word", {8'h00, init_exp[i]}, word_log[i]);
			check_val("init e width", 16'd20, width_log[i]);
		end
		check_val("cursor_row", 16'h0, cursor_row);
		check_val("cursor_col", 16'h0, cursor_col);

		for (int i = 0; i < NUM_STEPS; i++) begin
			send_req(steps[i].op, steps[i].row, steps[i].col, steps[i].arg);
			wait_words(5 + i, 200);
			wait_ready(200);
			check_val("bus word", {6'h00, steps[i].exp_rs, 1'b0, steps[i].exp_data},
				word_log[4 + i]);
			check_val("e width", 16'd26, width_log[4 + i]);
			check_val("cursor_row", steps[i].exp_row, cursor_row);
			check_val("cursor_col", steps[i].exp_col, cursor_col);
		end

		// the first word goes straight to the bus timer so four more fill the queue
		base = word_log.size();
		for (int i = 0; i < 4; i++) begin
			send_req(op_write_char, 1'b0, 6'd0, lcd_byte_t'(8'h61 + i));
		end
		check_val("full", 16'h0, full);
		send_req(op_write_char, 1'b0, 6'd0, 8'h65);
		check_val("full", 16'h1, full);
		send_req(op_write_char, 1'b0, 6'd0, 8'h66);
		wait_words(base + 6, 2000);
		wait_ready(200);
		for (int i = 0; i < 6; i++) begin
			check_val("bus word", {8'h02, lcd_byte_t'(8'h61 + i)}, word_log[base + i]);
		end
		check_val("cursor_col", 16'd6, cursor_col);
		end_run();
	end

endmodule

`default_nettype wire

/* lcd_text_display.f */
source/lcd_pkg.sv
source/lcd_cmd_decoder.sv
source/lcd_bus_timer.sv
source/lcd_cursor_tracker.sv
source/lcd_text_display.sv
verification/lcd_text_display_tb.sv
